// File: flist.f
+incdir+.
prep_pkg.sv
prep_dc_remove.sv
prep_diff.sv
prep_mag_cmp.sv
prep_blanker.sv
prep_top.sv
tb_prep_top.sv

// File: prep_blanker.sv
`default_nettype none

`include "prep_defs.svh"

module prep_blanker (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire prep_pkg::comb_mode_e i_comb_mode,
  input  wire prep_pkg::beat_t    i_data,
  input  wire                     i_data_valid,
  input  wire                     i_data_last,
  input  wire prep_pkg::mask_t    i_lf_flag,
  input  wire prep_pkg::mask_t    i_hf_flag,
  input  wire                     i_hf_valid,
  output prep_pkg::beat_t         o_y0,
  output logic                    o_y0_valid,
  output logic                    o_y0_last,
  output prep_pkg::mask_t         o_blank_mask
);

  import prep_pkg::*;

  beat_t data_d1;
  beat_t data_d2;
  logic  valid_d1;
  logic  valid_d2;
  logic  last_d1;
  logic  last_d2;
  mask_t lf_d1;
  mask_t sel_mask;
  beat_t blanked;

  // ------------------------------------------------------------------------
  // alignment delay line
  // ------------------------------------------------------------------------
  // data trails the HF flags by two stages, LF flags by one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d1 <= 1'b0;
      valid_d2 <= 1'b0;
      last_d1  <= 1'b0;
      last_d2  <= 1'b0;
      lf_d1    <= '0;
    end else begin
      valid_d1 <= i_data_valid;
      valid_d2 <= valid_d1;
      last_d1  <= i_data_valid & i_data_last;
      last_d2  <= last_d1;
      lf_d1    <= i_lf_flag;
    end
  end

  always_ff @(posedge clk) begin
    if (i_data_valid) begin
      data_d1 <= i_data;
    end
    if (valid_d1) begin
      data_d2 <= data_d1;
    end
  end

  // ------------------------------------------------------------------------
  // flag combination and blanking
  // ------------------------------------------------------------------------
  always_comb begin
    case (i_comb_mode)
      COMB_LF:  sel_mask = lf_d1;
      COMB_HF:  sel_mask = i_hf_flag;
      COMB_ANY: sel_mask = lf_d1 | i_hf_flag;
      default:  sel_mask = '0;
    endcase
  end

  for (genvar k = 0; k < `PREP_LANES; k++) begin : g_lane
    assign blanked[k*`PREP_SMP_W +: `PREP_SMP_W] =
        sel_mask[k] ? '0 : data_d2[k*`PREP_SMP_W +: `PREP_SMP_W];
  end

  // output stage, holds the last beat between strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_y0         <= '0;
      o_y0_valid   <= 1'b0;
      o_y0_last    <= 1'b0;
      o_blank_mask <= '0;
    end else begin
      o_y0_valid <= i_hf_valid & valid_d2;
      o_y0_last  <= last_d2;
      if (i_hf_valid & valid_d2) begin
        o_y0         <= blanked;
        o_blank_mask <= sel_mask;
      end
    end
  end

endmodule

`default_nettype wire

// File: prep_dc_remove.sv
`default_nettype none

`include "prep_defs.svh"

module prep_dc_remove (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire prep_pkg::prep_mode_e i_mode,
  input  wire [31:0]              i_dc_u,
  input  wire prep_pkg::beat_t    i_x0,
  input  wire                     i_x0_valid,
  input  wire                     i_x0_last,
  output prep_pkg::beat_t         o_y0,
  output logic                    o_y0_valid,
  output logic                    o_y0_last
);

  import prep_pkg::*;

  smp_t  dc_i;
  smp_t  dc_q;
  beat_t y_nxt;

  // I offset in the low half, Q offset in the high half
  assign dc_i = i_dc_u[15:0];
  assign dc_q = i_dc_u[31:16];

  // ------------------------------------------------------------------------
  // per-lane x - u with clamp
  // ------------------------------------------------------------------------
  for (genvar k = 0; k < `PREP_LANES; k++) begin : g_lane
    smp_t                       x;
    smp_t                       off;
    logic signed [`PREP_SMP_W:0] d;

    assign x = i_x0[k*`PREP_SMP_W +: `PREP_SMP_W];

    // odd lanes hold Q in complex mode
    assign off = (i_mode == PREP_COMPLEX && (k % 2) == 1) ? dc_q : dc_i;

    // one guard bit is enough for a single subtract
    assign d = {x[`PREP_SMP_W-1], x} - {off[`PREP_SMP_W-1], off};

    assign y_nxt[k*`PREP_SMP_W +: `PREP_SMP_W] = sat_smp(d);
  end

  // ------------------------------------------------------------------------
  // stage register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_y0_valid <= 1'b0;
      o_y0_last  <= 1'b0;
    end else begin
      o_y0_valid <= i_x0_valid;
      o_y0_last  <= i_x0_valid & i_x0_last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_x0_valid) begin
      o_y0 <= y_nxt;
    end
  end

endmodule

`default_nettype wire

// File: prep_defs.svh
`ifndef PREP_DEFS_SVH
`define PREP_DEFS_SVH

// ------------------------------------------------------------------------
// beat geometry, 16-bit sample mode
// ------------------------------------------------------------------------

// samples per beat
`define PREP_LANES 8

// I/Q pairs per beat in complex mode
`define PREP_CPLX_LANES 4

// signed sample width
`define PREP_SMP_W 16

// full beat, PREP_LANES x PREP_SMP_W
`define PREP_BEAT_W 128

// input valid to output valid, in clocks
`define PREP_LATENCY 4

`endif

// File: prep_diff.sv
`default_nettype none

`include "prep_defs.svh"

module prep_diff (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire prep_pkg::prep_mode_e i_mode,
  input  wire prep_pkg::beat_t    i_x0,
  input  wire                     i_x0_valid,
  input  wire                     i_x0_last,
  output prep_pkg::beat_t         o_y0,
  output logic                    o_y0_valid,
  output logic                    o_y0_last
);

  import prep_pkg::*;

  // lanes 6 and 7 of the previous beat
  smp_t  hist_lo;
  smp_t  hist_hi;
  // history in front of the current beat, ext[k+2] is lane k
  smp_t  ext [`PREP_LANES+2];
  beat_t y_nxt;

  assign ext[0] = hist_lo;
  assign ext[1] = hist_hi;

  // ------------------------------------------------------------------------
  // stream-order difference
  // ------------------------------------------------------------------------
  for (genvar k = 0; k < `PREP_LANES; k++) begin : g_lane
    smp_t                       prev;
    logic signed [`PREP_SMP_W:0] d;

    assign ext[k+2] = i_x0[k*`PREP_SMP_W +: `PREP_SMP_W];

    // step back one sample, or one whole pair in complex mode
    assign prev = (i_mode == PREP_COMPLEX) ? ext[k] : ext[k+1];

    assign d = {ext[k+2][`PREP_SMP_W-1], ext[k+2]} - {prev[`PREP_SMP_W-1], prev};

    assign y_nxt[k*`PREP_SMP_W +: `PREP_SMP_W] = sat_smp(d);
  end

  // history, cleared so a new packet starts from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist_lo <= '0;
      hist_hi <= '0;
    end else if (i_x0_valid) begin
      if (i_x0_last) begin
        hist_lo <= '0;
        hist_hi <= '0;
      end else begin
        hist_lo <= ext[`PREP_LANES];
        hist_hi <= ext[`PREP_LANES+1];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_y0_valid <= 1'b0;
      o_y0_last  <= 1'b0;
    end else begin
      o_y0_valid <= i_x0_valid;
      o_y0_last  <= i_x0_valid & i_x0_last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_x0_valid) begin
      o_y0 <= y_nxt;
    end
  end

endmodule

`default_nettype wire

// File: prep_mag_cmp.sv
`default_nettype none

`include "prep_defs.svh"

module prep_mag_cmp (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire prep_pkg::prep_mode_e i_mode,
  input  wire [15:0]              i_thr,
  input  wire prep_pkg::beat_t    i_x0,
  input  wire                     i_x0_valid,
  output prep_pkg::mask_t         o_flag,
  output logic                    o_flag_valid
);

  import prep_pkg::*;

  logic [`PREP_SMP_W-1:0]      mag [`PREP_LANES];
  mask_t                       real_flag;
  logic [`PREP_CPLX_LANES-1:0] cplx_flag;
  mask_t                       flag_nxt;

  // ------------------------------------------------------------------------
  // per-sample magnitude
  // ------------------------------------------------------------------------
  for (genvar k = 0; k < `PREP_LANES; k++) begin : g_lane
    smp_t x;

    assign x = i_x0[k*`PREP_SMP_W +: `PREP_SMP_W];

    // most negative value folds onto the positive rail
    assign mag[k] = !x[`PREP_SMP_W-1] ? x :
                    (x == 16'sh8000) ? 16'h7fff : 16'(~x + 16'd1);

    assign real_flag[k] = mag[k] > i_thr;
  end

  // ------------------------------------------------------------------------
  // L1 norm per I/Q pair
  // ------------------------------------------------------------------------
  for (genvar p = 0; p < `PREP_CPLX_LANES; p++) begin : g_pair
    logic [`PREP_SMP_W:0] l1;

    assign l1 = {1'b0, mag[2*p]} + {1'b0, mag[2*p+1]};
    assign cplx_flag[p] = l1 > {1'b0, i_thr};
  end

  // pair flag lands on both I and Q lanes
  for (genvar k = 0; k < `PREP_LANES; k++) begin : g_sel
    assign flag_nxt[k] = (i_mode == PREP_COMPLEX) ? cplx_flag[k/2] : real_flag[k];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_flag       <= '0;
      o_flag_valid <= 1'b0;
    end else begin
      o_flag       <= i_x0_valid ? flag_nxt : '0;
      o_flag_valid <= i_x0_valid;
    end
  end

endmodule

`default_nettype wire

// File: prep_pkg.sv
`default_nettype none

`include "prep_defs.svh"

package prep_pkg;

  // sample layout of a beat
  typedef enum logic {
    PREP_REAL    = 1'b0,
    PREP_COMPLEX = 1'b1
  } prep_mode_e;

  // which compare flags blank a sample
  typedef enum logic [1:0] {
    COMB_OFF = 2'd0,
    COMB_LF  = 2'd1,
    COMB_HF  = 2'd2,
    COMB_ANY = 2'd3
  } comb_mode_e;

  typedef logic signed [`PREP_SMP_W-1:0] smp_t;
  typedef logic [`PREP_BEAT_W-1:0] beat_t;
  typedef logic [`PREP_LANES-1:0] mask_t;

  // clamp a 17-bit difference back into a sample
  function automatic smp_t sat_smp(input logic signed [`PREP_SMP_W:0] v);
    if (v > 17'sd32767) return 16'sh7fff;
    if (v < -17'sd32768) return 16'sh8000;
    return v[`PREP_SMP_W-1:0];
  endfunction

endpackage

`default_nettype wire

// File: prep_top.sv
`default_nettype none

module prep_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire prep_pkg::prep_mode_e i_mode,
  input  wire prep_pkg::comb_mode_e i_comb_mode,
  input  wire [31:0]              i_dc_u,
  input  wire [15:0]              i_intf_thr,
  input  wire prep_pkg::beat_t    i_x0,
  input  wire                     i_x0_valid,
  input  wire                     i_x0_last,
  output prep_pkg::beat_t         o_y0,
  output logic                    o_y0_valid,
  output logic                    o_y0_last,
  output prep_pkg::mask_t         o_blank_mask
);

  import prep_pkg::*;

  // DC-removed stream, the LF path
  beat_t dc_y0;
  logic  dc_valid;
  logic  dc_last;

  // difference stream, the HF path
  beat_t diff_y0;
  logic  diff_valid;

  mask_t lf_flag;
  mask_t hf_flag;
  logic  hf_valid;

  // ------------------------------------------------------------------------
  // stage 1, x - u
  // ------------------------------------------------------------------------
  prep_dc_remove u_dc_remove (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_mode     (i_mode),
    .i_dc_u     (i_dc_u),
    .i_x0       (i_x0),
    .i_x0_valid (i_x0_valid),
    .i_x0_last  (i_x0_last),
    .o_y0       (dc_y0),
    .o_y0_valid (dc_valid),
    .o_y0_last  (dc_last)
  );

  // ------------------------------------------------------------------------
  // stage 2, difference and LF compare
  // ------------------------------------------------------------------------
  prep_diff u_diff (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_mode     (i_mode),
    .i_x0       (dc_y0),
    .i_x0_valid (dc_valid),
    .i_x0_last  (dc_last),
    .o_y0       (diff_y0),
    .o_y0_valid (diff_valid),
    .o_y0_last  ()
  );

  // LF flags come out one beat early, blanker re-aligns them
  prep_mag_cmp u_lf_cmp (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (i_mode),
    .i_thr        (i_intf_thr),
    .i_x0         (dc_y0),
    .i_x0_valid   (dc_valid),
    .o_flag       (lf_flag),
    .o_flag_valid ()
  );

  // ------------------------------------------------------------------------
  // stage 3, HF compare
  // ------------------------------------------------------------------------
  prep_mag_cmp u_hf_cmp (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (i_mode),
    .i_thr        (i_intf_thr),
    .i_x0         (diff_y0),
    .i_x0_valid   (diff_valid),
    .o_flag       (hf_flag),
    .o_flag_valid (hf_valid)
  );

  // ------------------------------------------------------------------------
  // stage 4, blanking
  // ------------------------------------------------------------------------
  prep_blanker u_blanker (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_comb_mode  (i_comb_mode),
    .i_data       (dc_y0),
    .i_data_valid (dc_valid),
    .i_data_last  (dc_last),
    .i_lf_flag    (lf_flag),
    .i_hf_flag    (hf_flag),
    .i_hf_valid   (hf_valid),
    .o_y0         (o_y0),
    .o_y0_valid   (o_y0_valid),
    .o_y0_last    (o_y0_last),
    .o_blank_mask (o_blank_mask)
  );

endmodule

`default_nettype wire

// File: tb_prep_top.sv
`default_nettype none

`include "prep_defs.svh"

module tb_prep_top;

  timeunit 1ns;
  timeprecision 1ps;

  import prep_pkg::*;

  localparam int DRAIN_TIMEOUT = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  prep_mode_e  i_mode;
  comb_mode_e  i_comb_mode;
  logic [31:0] i_dc_u;
  logic [15:0] i_intf_thr;
  beat_t       i_x0;
  logic        i_x0_valid;
  logic        i_x0_last;
  beat_t       o_y0;
  logic        o_y0_valid;
  logic        o_y0_last;
  mask_t       o_blank_mask;

  logic [15:0] lfsr_state = 16'd6;
  int          cyc = 0;
  // DC-removed lanes of the previous beat or zeros after last
  int          ref_hist [`PREP_LANES];

  beat_t exp_beat_q [$];
  mask_t exp_mask_q [$];
  bit    exp_last_q [$];
  int    exp_cyc_q [$];

  int beat_errs = 0;
  int mask_errs = 0;
  int strobe_errs = 0;
  int other_errs = 0;

  prep_top i_prep_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (i_mode),
    .i_comb_mode  (i_comb_mode),
    .i_dc_u       (i_dc_u),
    .i_intf_thr   (i_intf_thr),
    .i_x0         (i_x0),
    .i_x0_valid   (i_x0_valid),
    .i_x0_last    (i_x0_last),
    .o_y0         (o_y0),
    .o_y0_valid   (o_y0_valid),
    .o_y0_last    (o_y0_last),
    .o_blank_mask (o_blank_mask)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // --------------------------------------------------------------------------
  // random source with taps x^16 + x^14 + x^13 + x^11 + 1
  // --------------------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // shift narrows the sample range
  function automatic beat_t rand_beat(input int shift);
    beat_t b;
    smp_t  s;
    for (int k = 0; k < `PREP_LANES; k++) begin
      s = 16'(rand_bits(`PREP_SMP_W));
      s = s >>> shift;
      b[k*`PREP_SMP_W +: `PREP_SMP_W] = s;
    end
    return b;
  endfunction

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic int lane_val(input beat_t b, input int k);
    smp_t s;
    s = b[k*`PREP_SMP_W +: `PREP_SMP_W];
    return s;
  endfunction

  function automatic int clamp16(input int v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return v;
  endfunction

  function automatic int mag_of(input int v);
    if (v >= 0) return v;
    if (v == -32768) return 32767;
    return -v;
  endfunction

  function automatic mask_t flags_of(input beat_t b);
    mask_t f;
    int    l1;
    for (int p = 0; p < `PREP_CPLX_LANES; p++) begin
      if (i_mode == PREP_COMPLEX) begin
        l1 = mag_of(lane_val(b, 2*p)) + mag_of(lane_val(b, 2*p+1));
        f[2*p]   = l1 > int'(i_intf_thr);
        f[2*p+1] = f[2*p];
      end else begin
        f[2*p]   = mag_of(lane_val(b, 2*p)) > int'(i_intf_thr);
        f[2*p+1] = mag_of(lane_val(b, 2*p+1)) > int'(i_intf_thr);
      end
    end
    return f;
  endfunction

  function automatic void ref_model(input beat_t x, input bit last);
    smp_t  dc_i;
    smp_t  dc_q;
    int    off;
    int    prev;
    int    y [`PREP_LANES];
    int    d;
    beat_t y_beat;
    beat_t d_beat;
    mask_t sel;
    dc_i = i_dc_u[15:0];
    dc_q = i_dc_u[31:16];
    for (int k = 0; k < `PREP_LANES; k++) begin
      off = (i_mode == PREP_COMPLEX && k % 2 == 1) ? dc_q : dc_i;
      y[k] = clamp16(lane_val(x, k) - off);
      y_beat[k*`PREP_SMP_W +: `PREP_SMP_W] = y[k][15:0];
    end
    // previous sample or previous pair in complex mode
    for (int k = 0; k < `PREP_LANES; k++) begin
      if (i_mode == PREP_COMPLEX) begin
        prev = (k < 2) ? ref_hist[k+6] : y[k-2];
      end else begin
        prev = (k == 0) ? ref_hist[7] : y[k-1];
      end
      d = clamp16(y[k] - prev);
      d_beat[k*`PREP_SMP_W +: `PREP_SMP_W] = d[15:0];
    end
    for (int k = 0; k < `PREP_LANES; k++) begin
      ref_hist[k] = last ? 0 : y[k];
    end
    case (i_comb_mode)
      COMB_LF:  sel = flags_of(y_beat);
      COMB_HF:  sel = flags_of(d_beat);
      COMB_ANY: sel = flags_of(y_beat) | flags_of(d_beat);
      default:  sel = '0;
    endcase
    for (int k = 0; k < `PREP_LANES; k++) begin
      if (sel[k]) y_beat[k*`PREP_SMP_W +: `PREP_SMP_W] = '0;
    end
    exp_beat_q.push_back(y_beat);
    exp_mask_q.push_back(sel);
    exp_last_q.push_back(last);
    exp_cyc_q.push_back(cyc + `PREP_LATENCY);
  endfunction

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      beat_errs++;
    end
  endtask

  task automatic check_mask(input string name, input mask_t got, input mask_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      mask_errs++;
    end
  endtask

  task automatic check_last(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      strobe_errs++;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    int ec;
    if (o_y0_valid) begin
      if (exp_beat_q.size() == 0) begin
        $display("output beat at cycle %0d with no input beat pending", cyc);
        other_errs++;
      end else begin
        check_beat("o_y0", o_y0, exp_beat_q.pop_front());
        check_mask("o_blank_mask", o_blank_mask, exp_mask_q.pop_front());
        check_last("o_y0_last", o_y0_last, exp_last_q.pop_front());
        ec = exp_cyc_q.pop_front();
        if (cyc != ec) begin
          $display("output beat arrived at cycle %0d instead of cycle %0d", cyc, ec);
          other_errs++;
        end
      end
    end else if (o_y0_last) begin
      $display("o_y0_last high without o_y0_valid at cycle %0d", cyc);
      other_errs++;
    end
  end

  task automatic report_and_finish();
    $display("errors: o_y0 %0d, o_blank_mask %0d, strobes %0d, other %0d",
             beat_errs, mask_errs, strobe_errs, other_errs);
    if (beat_errs + mask_errs + strobe_errs + other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // called on a falling edge and returns on the next one
  task automatic send_beat(input beat_t x, input bit last);
    i_x0       = x;
    i_x0_valid = 1'b1;
    i_x0_last  = last;
    ref_model(x, last);
    @(negedge clk);
    i_x0_valid = 1'b0;
    i_x0_last  = 1'b0;
  endtask

  // negative gap picks a random gap of 0 to 3 cycles
  task automatic send_packet(input int n, input int shift, input int gap);
    int g;
    for (int i = 0; i < n; i++) begin
      send_beat(rand_beat(shift), i == n - 1);
      g = (gap < 0) ? int'(rand_bits(2)) : gap;
      idle(g);
    end
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (exp_beat_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_beat_q.size() != 0) begin
      $display("timeout, %s still in the DUT after %0d cycles", what, DRAIN_TIMEOUT);
      other_errs++;
      report_and_finish();
    end
  endtask

  // clamp at both rails with one beat per packet
  task automatic send_clamp_beats();
    i_dc_u = 32'h0000_8000;
    send_beat({`PREP_LANES{16'h7fff}}, 1'b1);
    i_dc_u = 32'h0000_7fff;
    send_beat({`PREP_LANES{16'h8000}}, 1'b1);
    i_dc_u = 32'h1234_ffff;
    send_beat({`PREP_CPLX_LANES{32'h8000_7fff}}, 1'b1);
    i_dc_u = 32'h0000_0001;
    send_beat({`PREP_CPLX_LANES{32'h8000_7fff}}, 1'b1);
  endtask

  initial begin
    rst_n       = 1'b0;
    i_mode      = PREP_REAL;
    i_comb_mode = COMB_OFF;
    i_dc_u      = '0;
    i_intf_thr  = '0;
    i_x0        = '0;
    i_x0_valid  = 1'b0;
    i_x0_last   = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    idle(1);

    // reset state
    check_last("o_y0_valid", o_y0_valid, 1'b0);
    check_last("o_y0_last", o_y0_last, 1'b0);
    check_mask("o_blank_mask", o_blank_mask, '0);
    check_beat("o_y0", o_y0, '0);

    // real mode with DC removal only
    i_intf_thr = 16'h4000;
    i_dc_u     = rand_bits(32);
    send_packet(6, 0, 0);
    send_clamp_beats();
    wait_drain("real DC packets");

    // latency with gaps
    i_dc_u = rand_bits(32);
    send_packet(5, 1, 2);
    send_packet(4, 1, -1);
    wait_drain("gapped packets");

    // complex mode with LF blanking in pairs
    i_mode      = PREP_COMPLEX;
    i_comb_mode = COMB_LF;
    i_intf_thr  = 16'h8000;
    i_dc_u      = {8'h00, 8'(rand_bits(8)), 8'h00, 8'(rand_bits(8))};
    send_packet(4, 0, 0);
    send_packet(3, 0, 1);
    wait_drain("complex LF packets");

    // real mode with HF flags over several packets
    i_mode      = PREP_REAL;
    i_comb_mode = COMB_HF;
    i_intf_thr  = 16'h2000;
    i_dc_u      = '0;
    for (int p = 0; p < 3; p++) begin
      send_packet(3, 2, 0);
      idle(2);
    end
    // lane-0 history carried within a packet and cleared after last
    send_beat({16'h1fff, 112'h0}, 1'b0);
    send_beat({16'h1fff, 96'h0, 16'he001}, 1'b1);
    send_beat({112'h0, 16'he001}, 1'b1);
    wait_drain("real HF packets");

    // either flag in both modes
    i_comb_mode = COMB_ANY;
    i_intf_thr  = 16'h5000;
    i_dc_u      = rand_bits(32);
    send_packet(4, 1, -1);
    send_packet(4, 1, -1);
    wait_drain("real ANY packets");
    i_mode     = PREP_COMPLEX;
    i_intf_thr = 16'h9000;
    send_packet(4, 0, -1);
    send_packet(4, 0, -1);
    wait_drain("complex ANY packets");

    idle(5);
    report_and_finish();
  end

endmodule

`default_nettype wire
